//--- Bender.yml
package:
  name: ptw

sources:
  - hw/ptw_pkg.sv
  - hw/ptw_walk_ctrl.sv
  - hw/ptw_pte_check.sv
  - hw/ptw_mem_port.sv
  - hw/ptw_tlb_update.sv
  - hw/ptw_top.sv
  - target: simulation
    files:
      - tests/tb_ptw_mem.sv
      - tests/tb_ptw.sv

//--- compile.f
hw/ptw_pkg.sv
hw/ptw_walk_ctrl.sv
hw/ptw_pte_check.sv
hw/ptw_mem_port.sv
hw/ptw_tlb_update.sv
hw/ptw_top.sv
tests/tb_ptw_mem.sv
tests/tb_ptw.sv

//--- hw/ptw_mem_port.sv
`default_nettype none

module ptw_mem_port (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     data_req_i,
  input  logic [ptw_pkg::PLEN-1:0] pptr_i,
  input  ptw_pkg::dc_rsp_t         req_port_i,
  output ptw_pkg::dc_req_t         req_port_o,
  output logic                     data_gnt_o,
  output logic                     rvalid_o,
  output ptw_pkg::pte_t            pte_o
);

  logic tag_valid_q;
  logic rvalid_q;
  logic [ptw_pkg::XLEN-1:0] rdata_q;

  // ------------------------------
  // request side
  // ------------------------------
  // low bits index the cache and the rest goes out with tag_valid
  assign req_port_o.data_req      = data_req_i;
  assign req_port_o.address_index = pptr_i[ptw_pkg::DC_INDEX_W-1:0];
  assign req_port_o.address_tag   =
    pptr_i[ptw_pkg::DC_INDEX_W + ptw_pkg::DC_TAG_W - 1:ptw_pkg::DC_INDEX_W];
  assign req_port_o.tag_valid     = tag_valid_q;

  // grant only counts for our own pending request
  assign data_gnt_o = req_port_i.data_gnt && data_req_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tag_valid_q <= 1'b0;
      rvalid_q    <= 1'b0;
    end else begin
      // tag is presented the cycle after grant
      tag_valid_q <= data_req_i && req_port_i.data_gnt;
      rvalid_q    <= req_port_i.data_rvalid;
    end
  end

  // response data sampled every cycle
  always_ff @(posedge clk_i) begin
    rdata_q <= req_port_i.data_rdata;
  end

  assign rvalid_o = rvalid_q;
  assign pte_o    = ptw_pkg::pte_t'(rdata_q);

endmodule

`default_nettype wire

//--- hw/ptw_pkg.sv
`default_nettype none

package ptw_pkg;

  // ------------------------------
  // sv39 geometry
  // ------------------------------
  // data width of the cache port and of one pte
  localparam int unsigned XLEN          = 64;
  localparam int unsigned VLEN          = 39;
  localparam int unsigned PLEN          = 56;
  localparam int unsigned PPN_W         = 44;
  localparam int unsigned PT_LEVELS     = 3;
  localparam int unsigned VPN_W         = 9;
  localparam int unsigned PAGE_OFF_W    = 12;
  // ptes are 8 bytes wide
  localparam int unsigned PTE_SIZE_LOG2 = 3;
  localparam int unsigned ASID_W        = 16;
  // full vpn carried in a tlb entry
  localparam int unsigned VPN_TOTAL_W   = PT_LEVELS * VPN_W;

  // ------------------------------
  // data cache port
  // ------------------------------
  // index plus tag covers the whole physical address
  localparam int unsigned DC_INDEX_W = 12;
  localparam int unsigned DC_TAG_W   = 44;

  // level counter with 0 as the root table
  localparam int unsigned LVL_W = 2;

  // sv39 page table entry with the msb first
  typedef struct packed {
    logic [9:0]       reserved;
    logic [PPN_W-1:0] ppn;
    logic [1:0]       rsw;
    logic             d;
    logic             a;
    logic             g;
    logic             u;
    logic             x;
    logic             w;
    logic             r;
    logic             v;
  } pte_t;

  // read-only request toward the data cache
  typedef struct packed {
    logic                  data_req;
    logic [DC_INDEX_W-1:0] address_index;
    logic [DC_TAG_W-1:0]   address_tag;
    logic                  tag_valid;
  } dc_req_t;

  // cache answer with grant then rvalid and data
  typedef struct packed {
    logic            data_gnt;
    logic            data_rvalid;
    logic [XLEN-1:0] data_rdata;
  } dc_rsp_t;

  // entry written into the shared tlb
  typedef struct packed {
    logic                   valid;
    logic                   is_1g;
    logic                   is_2m;
    logic [VPN_TOTAL_W-1:0] vpn;
    logic [ASID_W-1:0]      asid;
    pte_t                   content;
  } tlb_update_t;

  typedef enum logic [2:0] {
    IDLE,
    WAIT_GRANT,
    PTE_LOOKUP,
    PROPAGATE_ERROR,
    WAIT_RVALID,
    LATENCY
  } walk_state_e;

  // verdict on one returned pte
  typedef enum logic [1:0] {
    PTE_INVALID,
    PTE_POINTER,
    PTE_LEAF_OK,
    PTE_LEAF_FAULT
  } pte_class_e;

endpackage

`default_nettype wire

//--- hw/ptw_pte_check.sv
`default_nettype none

module ptw_pte_check (
  input  ptw_pkg::pte_t             pte_i,
  input  logic [ptw_pkg::LVL_W-1:0] level_i,
  input  logic                      is_instr_i,
  input  logic                      is_store_i,
  input  logic                      mxr_i,
  output ptw_pkg::pte_class_e       pte_class_o
);

  logic invalid;
  logic is_leaf;
  logic misaligned;
  logic perm_fault;
  logic last_level;

  // v clear, write-only or reserved bits set
  assign invalid = !pte_i.v || (pte_i.w && !pte_i.r) || (|pte_i.reserved);

  // r or x marks a leaf and anything else points one level down
  assign is_leaf = pte_i.r || pte_i.x;

  assign last_level = (level_i == (ptw_pkg::PT_LEVELS - 1));

  // superpage leaves need the ppn slices below them cleared
  always_comb begin
    case (level_i)
      2'd0:    misaligned = |pte_i.ppn[2*ptw_pkg::VPN_W-1:0];
      2'd1:    misaligned = |pte_i.ppn[ptw_pkg::VPN_W-1:0];
      default: misaligned = 1'b0;
    endcase
  end

  // ------------------------------
  // leaf permissions
  // ------------------------------
  always_comb begin
    // accessed bit is managed by software
    perm_fault = !pte_i.a;
    if (is_instr_i) begin
      perm_fault = perm_fault || !pte_i.x;
    end else begin
      // mxr lets loads read execute-only pages
      perm_fault = perm_fault || !(pte_i.r || (pte_i.x && mxr_i));
      // stores need write permission and a set dirty bit
      perm_fault = perm_fault || (is_store_i && !(pte_i.w && pte_i.d));
    end
  end

  always_comb begin
    if (invalid) begin
      pte_class_o = ptw_pkg::PTE_INVALID;
    end else if (!is_leaf) begin
      // no table below the last level
      pte_class_o = last_level ? ptw_pkg::PTE_INVALID : ptw_pkg::PTE_POINTER;
    end else if (misaligned || perm_fault) begin
      pte_class_o = ptw_pkg::PTE_LEAF_FAULT;
    end else begin
      pte_class_o = ptw_pkg::PTE_LEAF_OK;
    end
  end

endmodule

`default_nettype wire

//--- hw/ptw_tlb_update.sv
`default_nettype none

module ptw_tlb_update (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       start_i,
  input  logic                       pte_seen_i,
  input  logic                       update_i,
  input  logic                       itlb_req_i,
  input  logic                       enable_translation_i,
  input  logic [ptw_pkg::ASID_W-1:0] asid_i,
  input  logic [ptw_pkg::LVL_W-1:0]  level_i,
  input  logic [ptw_pkg::VLEN-1:0]   vaddr_i,
  input  ptw_pkg::pte_t              pte_i,
  output ptw_pkg::tlb_update_t       update_o
);

  logic [ptw_pkg::ASID_W-1:0] asid_q;
  logic [ptw_pkg::ASID_W-1:0] asid_sel;
  logic global_q;
  ptw_pkg::pte_t content;

  // fetch walks carry the asid only under fetch translation
  // and data walks always take it
  assign asid_sel = (itlb_req_i && !enable_translation_i) ? '0 : asid_i;

  // ------------------------------
  // per walk state
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      asid_q   <= '0;
      global_q <= 1'b0;
    end else if (start_i) begin
      asid_q   <= asid_sel;
      global_q <= 1'b0;
    end else if (pte_seen_i) begin
      // any global entry on the path makes the leaf global
      global_q <= global_q || pte_i.g;
    end
  end

  // leaf content with the accumulated global bit
  always_comb begin
    content   = pte_i;
    content.g = pte_i.g || global_q;
  end

  // ------------------------------
  // update record
  // ------------------------------
  always_comb begin
    update_o.valid   = update_i;
    // leaf level gives the page size
    update_o.is_1g   = (level_i == 2'd0);
    update_o.is_2m   = (level_i == 2'd1);
    update_o.vpn     = vaddr_i[ptw_pkg::VLEN-1:ptw_pkg::PAGE_OFF_W];
    update_o.asid    = asid_q;
    update_o.content = content;
  end

endmodule

`default_nettype wire

//--- hw/ptw_top.sv
`default_nettype none

module ptw_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,
  input  logic                       enable_translation_i,
  input  logic                       en_ld_st_translation_i,
  input  logic                       lsu_is_store_i,
  input  logic                       itlb_req_i,
  input  logic                       shared_tlb_access_i,
  input  logic                       shared_tlb_hit_i,
  input  logic                       mxr_i,
  input  logic [ptw_pkg::VLEN-1:0]   shared_tlb_vaddr_i,
  input  logic [ptw_pkg::PPN_W-1:0]  satp_ppn_i,
  input  logic [ptw_pkg::ASID_W-1:0] asid_i,
  input  ptw_pkg::dc_rsp_t           req_port_i,
  output ptw_pkg::dc_req_t           req_port_o,
  output ptw_pkg::tlb_update_t       shared_tlb_update_o,
  output logic [ptw_pkg::VLEN-1:0]   update_vaddr_o,
  output logic                       ptw_active_o,
  output logic                       walking_instr_o,
  output logic                       ptw_error_o,
  output logic                       shared_tlb_miss_o
);

  logic data_req;
  logic data_gnt;
  logic rvalid_q;
  logic [ptw_pkg::PLEN-1:0] pptr;
  logic [ptw_pkg::LVL_W-1:0] level;
  logic is_instr;
  logic start;
  logic pte_seen;
  logic update;
  ptw_pkg::pte_t pte_q;
  ptw_pkg::pte_class_e pte_class;

  // ------------------------------
  // walk control
  // ------------------------------
  ptw_walk_ctrl i_walk_ctrl (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .flush_i                (flush_i),
    .enable_translation_i   (enable_translation_i),
    .en_ld_st_translation_i (en_ld_st_translation_i),
    .shared_tlb_access_i    (shared_tlb_access_i),
    .shared_tlb_hit_i       (shared_tlb_hit_i),
    .itlb_req_i             (itlb_req_i),
    .shared_tlb_vaddr_i     (shared_tlb_vaddr_i),
    .satp_ppn_i             (satp_ppn_i),
    .data_gnt_i             (data_gnt),
    .rvalid_i               (rvalid_q),
    .pte_i                  (pte_q),
    .pte_class_i            (pte_class),
    .data_req_o             (data_req),
    .pptr_o                 (pptr),
    .level_o                (level),
    .is_instr_o             (is_instr),
    .start_o                (start),
    .pte_seen_o             (pte_seen),
    .update_o               (update),
    .error_o                (ptw_error_o),
    .miss_o                 (shared_tlb_miss_o),
    .active_o               (ptw_active_o),
    .vaddr_o                (update_vaddr_o)
  );

  // classification of the registered pte
  ptw_pte_check i_pte_check (
    .pte_i       (pte_q),
    .level_i     (level),
    .is_instr_i  (is_instr),
    .is_store_i  (lsu_is_store_i),
    .mxr_i       (mxr_i),
    .pte_class_o (pte_class)
  );

  ptw_mem_port i_mem_port (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .data_req_i (data_req),
    .pptr_i     (pptr),
    .req_port_i (req_port_i),
    .req_port_o (req_port_o),
    .data_gnt_o (data_gnt),
    .rvalid_o   (rvalid_q),
    .pte_o      (pte_q)
  );

  ptw_tlb_update i_tlb_update (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .start_i              (start),
    .pte_seen_i           (pte_seen),
    .update_i             (update),
    .itlb_req_i           (itlb_req_i),
    .enable_translation_i (enable_translation_i),
    .asid_i               (asid_i),
    .level_i              (level),
    .vaddr_i              (update_vaddr_o),
    .pte_i                (pte_q),
    .update_o             (shared_tlb_update_o)
  );

  assign walking_instr_o = is_instr;

endmodule

`default_nettype wire

//--- hw/ptw_walk_ctrl.sv
`default_nettype none

module ptw_walk_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        flush_i,
  input  logic                        enable_translation_i,
  input  logic                        en_ld_st_translation_i,
  input  logic                        shared_tlb_access_i,
  input  logic                        shared_tlb_hit_i,
  input  logic                        itlb_req_i,
  input  logic [ptw_pkg::VLEN-1:0]    shared_tlb_vaddr_i,
  input  logic [ptw_pkg::PPN_W-1:0]   satp_ppn_i,
  input  logic                        data_gnt_i,
  input  logic                        rvalid_i,
  input  ptw_pkg::pte_t               pte_i,
  input  ptw_pkg::pte_class_e         pte_class_i,
  output logic                        data_req_o,
  output logic [ptw_pkg::PLEN-1:0]    pptr_o,
  output logic [ptw_pkg::LVL_W-1:0]   level_o,
  output logic                        is_instr_o,
  output logic                        start_o,
  output logic                        pte_seen_o,
  output logic                        update_o,
  output logic                        error_o,
  output logic                        miss_o,
  output logic                        active_o,
  output logic [ptw_pkg::VLEN-1:0]    vaddr_o
);

  ptw_pkg::walk_state_e state_q, state_d;
  logic [ptw_pkg::LVL_W-1:0] level_q, level_d;
  logic is_instr_q, is_instr_d;
  logic [ptw_pkg::VLEN-1:0] vaddr_q, vaddr_d;
  logic [ptw_pkg::PLEN-1:0] pptr_q, pptr_d;
  logic miss;
  logic [ptw_pkg::VPN_W-1:0] root_vpn;
  logic [ptw_pkg::VPN_W-1:0] next_vpn;

  // a miss is only taken from idle and never in a flush cycle
  assign miss = (state_q == ptw_pkg::IDLE) && shared_tlb_access_i && !shared_tlb_hit_i &&
                (enable_translation_i || en_ld_st_translation_i) && !flush_i;

  // vpn[2] indexes the root table
  assign root_vpn = shared_tlb_vaddr_i[ptw_pkg::PAGE_OFF_W + 2*ptw_pkg::VPN_W +: ptw_pkg::VPN_W];
  // slice for the table one level below the current one
  assign next_vpn = (level_q == '0) ?
                    vaddr_q[ptw_pkg::PAGE_OFF_W + ptw_pkg::VPN_W +: ptw_pkg::VPN_W] :
                    vaddr_q[ptw_pkg::PAGE_OFF_W +: ptw_pkg::VPN_W];

  assign data_req_o = (state_q == ptw_pkg::WAIT_GRANT);
  assign active_o   = (state_q != ptw_pkg::IDLE);
  assign miss_o     = miss;
  assign start_o    = miss;
  // a flushed walk reports nothing
  assign error_o    = (state_q == ptw_pkg::PROPAGATE_ERROR) && !flush_i;
  assign pptr_o     = pptr_q;
  assign level_o    = level_q;
  assign is_instr_o = is_instr_q;
  assign vaddr_o    = vaddr_q;

  // ------------------------------
  // walk fsm
  // ------------------------------
  always_comb begin
    state_d    = state_q;
    level_d    = level_q;
    is_instr_d = is_instr_q;
    vaddr_d    = vaddr_q;
    pptr_d     = pptr_q;
    update_o   = 1'b0;
    pte_seen_o = 1'b0;

    case (state_q)
      ptw_pkg::IDLE: begin
        if (miss) begin
          level_d    = '0;
          is_instr_d = itlb_req_i;
          vaddr_d    = shared_tlb_vaddr_i;
          // root pte address from satp
          pptr_d     = {satp_ppn_i, root_vpn, {ptw_pkg::PTE_SIZE_LOG2{1'b0}}};
          state_d    = ptw_pkg::WAIT_GRANT;
        end
      end
      ptw_pkg::WAIT_GRANT: begin
        // request stays up until the cache grants
        if (data_gnt_i) begin
          state_d = ptw_pkg::PTE_LOOKUP;
        end
      end
      ptw_pkg::PTE_LOOKUP: begin
        if (rvalid_i) begin
          // global bit only counts for well formed entries
          pte_seen_o = (pte_class_i != ptw_pkg::PTE_INVALID);
          case (pte_class_i)
            ptw_pkg::PTE_POINTER: begin
              level_d = level_q + 1'b1;
              pptr_d  = {pte_i.ppn, next_vpn, {ptw_pkg::PTE_SIZE_LOG2{1'b0}}};
              state_d = ptw_pkg::WAIT_GRANT;
            end
            ptw_pkg::PTE_LEAF_OK: begin
              update_o = 1'b1;
              state_d  = ptw_pkg::LATENCY;
            end
            // invalid entries and faulting leaves end the same way
            default: begin
              state_d = ptw_pkg::PROPAGATE_ERROR;
            end
          endcase
        end
      end
      ptw_pkg::PROPAGATE_ERROR: begin
        state_d = ptw_pkg::LATENCY;
      end
      ptw_pkg::WAIT_RVALID: begin
        // drain the response of a flushed request
        if (rvalid_i) begin
          state_d = ptw_pkg::IDLE;
        end
      end
      ptw_pkg::LATENCY: begin
        state_d = ptw_pkg::IDLE;
      end
      default: begin
        state_d = ptw_pkg::IDLE;
      end
    endcase

    // a flush waits out a response still on its way or drops the walk
    if (flush_i && (state_q != ptw_pkg::IDLE)) begin
      update_o   = 1'b0;
      pte_seen_o = 1'b0;
      if (((state_q == ptw_pkg::PTE_LOOKUP || state_q == ptw_pkg::WAIT_RVALID) && !rvalid_i) ||
          ((state_q == ptw_pkg::WAIT_GRANT) && data_gnt_i)) begin
        state_d = ptw_pkg::WAIT_RVALID;
      end else begin
        state_d = ptw_pkg::LATENCY;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ptw_pkg::IDLE;
      level_q    <= '0;
      is_instr_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      level_q    <= level_d;
      is_instr_q <= is_instr_d;
    end
  end

  // captured walk payload
  always_ff @(posedge clk_i) begin
    vaddr_q <= vaddr_d;
    pptr_q  <= pptr_d;
  end

endmodule

`default_nettype wire

//--- tests/tb_ptw.sv
`default_nettype none

module tb_ptw;
  timeunit 1ns;
  timeprecision 1ns;

  localparam int unsigned TIMEOUT = 200;
  localparam logic [ptw_pkg::PPN_W-1:0] ROOT_PPN = 44'h80000;
  localparam logic [ptw_pkg::ASID_W-1:0] ASID = 16'h5a3c;

  logic clk_i;
  logic rst_ni;
  logic flush_i;
  logic enable_translation_i;
  logic en_ld_st_translation_i;
  logic lsu_is_store_i;
  logic itlb_req_i;
  logic shared_tlb_access_i;
  logic shared_tlb_hit_i;
  logic mxr_i;
  logic [ptw_pkg::VLEN-1:0] shared_tlb_vaddr_i;
  logic [ptw_pkg::PPN_W-1:0] satp_ppn_i;
  logic [ptw_pkg::ASID_W-1:0] asid_i;
  ptw_pkg::dc_rsp_t req_port_i;
  ptw_pkg::dc_req_t req_port_o;
  ptw_pkg::tlb_update_t upd;
  ptw_pkg::tlb_update_t exp_upd;
  logic [ptw_pkg::VLEN-1:0] exp_va;
  logic exp_instr;
  logic [ptw_pkg::VLEN-1:0] update_vaddr_o;
  logic ptw_active_o;
  logic walking_instr_o;
  logic ptw_error_o;
  logic shared_tlb_miss_o;

  integer seed = 60947;
  int unsigned mism;
  int unsigned timeouts;
  int unsigned mem_errors;
  int unsigned n_upd;
  int unsigned n_err;
  int unsigned n_miss;
  int unsigned n_req;
  int unsigned n_act;

  ptw_top i_ptw_top (
    .clk_i, .rst_ni, .flush_i, .enable_translation_i, .en_ld_st_translation_i,
    .lsu_is_store_i, .itlb_req_i, .shared_tlb_access_i, .shared_tlb_hit_i, .mxr_i,
    .shared_tlb_vaddr_i, .satp_ppn_i, .asid_i, .req_port_i, .req_port_o,
    .shared_tlb_update_o (upd), .update_vaddr_o, .ptw_active_o, .walking_instr_o,
    .ptw_error_o, .shared_tlb_miss_o
  );

  tb_ptw_mem i_mem (
    .clk_i, .rst_ni, .req_i (req_port_o), .rsp_o (req_port_i), .errors_o (mem_errors)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // ------------------------------
  // output monitor
  // ------------------------------
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (upd.valid) begin
        n_upd++;
        assert (upd == exp_upd) else begin
          mism++;
          $display("Mismatch at %0t: tlb update %h, expected %h", $time, upd, exp_upd);
        end
      end
      // walk type and vaddr travel with every walk result
      if (upd.valid || ptw_error_o) begin
        assert (walking_instr_o == exp_instr && update_vaddr_o == exp_va) else begin
          mism++;
          $display("Mismatch at %0t: walk type %b vaddr %h, expected %b %h", $time,
                   walking_instr_o, update_vaddr_o, exp_instr, exp_va);
        end
      end
      if (ptw_error_o) n_err++;
      if (shared_tlb_miss_o) n_miss++;
      if (req_port_o.data_req) n_req++;
      if (ptw_active_o) n_act++;
    end
  end

  function automatic ptw_pkg::pte_t make_pte(input logic [ptw_pkg::PPN_W-1:0] ppn,
                                             input logic [7:0] bits);
    // bits are d a g u x w r v
    return ptw_pkg::pte_t'({10'b0, ppn, 2'b0, bits});
  endfunction

  // page tables for one walk with the next tables at ROOT_PPN + 1 and + 2
  task automatic build_walk(input logic [38:0] va, input int lvl_leaf,
                            input ptw_pkg::pte_t leaf, input logic root_g);
    logic [ptw_pkg::PPN_W-1:0] ppn;
    logic [ptw_pkg::PLEN-1:0] a;
    int lvl;
    i_mem.clear_expected();
    ppn = ROOT_PPN;
    for (lvl = 0; lvl <= lvl_leaf; lvl++) begin
      a = {ppn, 12'b0} + ptw_pkg::PLEN'(va[12 + 9*(2-lvl) +: 9]) * 8;
      i_mem.expect_addr(a);
      if (lvl == lvl_leaf) begin
        i_mem.write_pte(a, leaf);
      end else begin
        ppn = ROOT_PPN + lvl + 1;
        i_mem.write_pte(a, make_pte(ppn, {2'b00, root_g && lvl == 0, 4'b0000, 1'b1}));
      end
    end
    exp_upd.valid   = 1'b1;
    exp_upd.is_1g   = (lvl_leaf == 0);
    exp_upd.is_2m   = (lvl_leaf == 1);
    exp_upd.vpn     = va[38:12];
    exp_upd.asid    = ASID;
    exp_upd.content = leaf;
    exp_upd.content.g = leaf.g | root_g;
  endtask

  task automatic clear_counts();
    @(negedge clk_i);
    n_upd = 0;
    n_err = 0;
    n_miss = 0;
    n_req = 0;
    n_act = 0;
  endtask

  task automatic start_miss(input logic [38:0] va, input logic instr, input logic store,
                            input logic mxr);
    clear_counts();
    exp_va    = va;
    exp_instr = instr;
    @(posedge clk_i);
    shared_tlb_access_i <= 1'b1;
    shared_tlb_vaddr_i  <= va;
    itlb_req_i          <= instr;
    lsu_is_store_i      <= store;
    mxr_i               <= mxr;
    @(posedge clk_i);
    shared_tlb_access_i <= 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    @(negedge clk_i);
    while (ptw_active_o && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (ptw_active_o) begin
      timeouts++;
      $display("Timeout at %0t: walker still busy after %0d cycles", $time, TIMEOUT);
    end
  endtask

  task automatic walk(input int lvl_leaf, input ptw_pkg::pte_t leaf, input logic root_g,
                      input logic instr, input logic store, input logic mxr, input logic ok);
    logic [38:0] va;
    va = {$random(seed), $random(seed)};
    build_walk(va, lvl_leaf, leaf, root_g);
    start_miss(va, instr, store, mxr);
    wait_idle();
    assert (n_miss == 1 && n_upd == ok && n_err == !ok) else begin
      mism++;
      $display("Mismatch at %0t: miss %0d update %0d error %0d, expected ok %b", $time,
               n_miss, n_upd, n_err, ok);
    end
  endtask

  task automatic no_walk(input logic hit, input logic en);
    clear_counts();
    @(posedge clk_i);
    shared_tlb_access_i    <= 1'b1;
    shared_tlb_hit_i       <= hit;
    enable_translation_i   <= en;
    en_ld_st_translation_i <= en;
    repeat (3) @(posedge clk_i);
    shared_tlb_access_i    <= 1'b0;
    shared_tlb_hit_i       <= 1'b0;
    enable_translation_i   <= 1'b1;
    en_ld_st_translation_i <= 1'b1;
    repeat (3) @(posedge clk_i);
    assert (n_miss == 0 && n_req == 0 && n_act == 0) else begin
      mism++;
      $display("Mismatch at %0t: walk started with hit %b enable %b", $time, hit, en);
    end
  endtask

  // flush somewhere inside a 4k walk of at least twelve cycles
  task automatic flush_walk();
    logic [38:0] va;
    int delay;
    va = {$random(seed), $random(seed)};
    delay = 1 + $unsigned($random(seed)) % 6;
    build_walk(va, 2, make_pte(44'h1234, 8'b11000111), 1'b0);
    start_miss(va, 1'b0, 1'b0, 1'b0);
    repeat (delay) @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    wait_idle();
    assert (n_upd == 0 && n_err == 0) else begin
      mism++;
      $display("Mismatch at %0t: flushed walk reported update %0d error %0d", $time,
               n_upd, n_err);
    end
  endtask

  initial begin
    ptw_pkg::pte_t bad;
    rst_ni <= 1'b0;
    flush_i <= 1'b0;
    enable_translation_i <= 1'b1;
    en_ld_st_translation_i <= 1'b1;
    lsu_is_store_i <= 1'b0;
    itlb_req_i <= 1'b0;
    shared_tlb_access_i <= 1'b0;
    shared_tlb_hit_i <= 1'b0;
    mxr_i <= 1'b0;
    shared_tlb_vaddr_i <= '0;
    satp_ppn_i <= ROOT_PPN;
    asid_i <= ASID;
    exp_upd = '0;
    exp_va = '0;
    exp_instr = 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    // 4k page with global only at the root
    walk(2, make_pte(44'h1234, 8'b11000111), 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
    // superpages, then a misaligned 2m leaf
    walk(0, make_pte(44'h40000, 8'b11000111), 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    walk(1, make_pte(44'h00e00, 8'b11000111), 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    walk(1, make_pte(44'h00e01, 8'b11000111), 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    // permissions
    walk(2, make_pte(44'h1234, 8'b11000111), 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    walk(2, make_pte(44'h1234, 8'b01000111), 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    walk(2, make_pte(44'h1234, 8'b11001001), 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    walk(2, make_pte(44'h1234, 8'b11001001), 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
    walk(2, make_pte(44'h1234, 8'b10000011), 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    // invalid entries
    walk(2, make_pte(44'h1234, 8'b11000110), 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    walk(2, make_pte(44'h1234, 8'b11000101), 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    bad = make_pte(44'h1234, 8'b11000111);
    bad.reserved = 10'h200;
    walk(2, bad, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    walk(2, make_pte(44'h1234, 8'b00000001), 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    // no walk on a hit or with translation off
    no_walk(1'b1, 1'b1);
    no_walk(1'b0, 1'b0);
    // flushes, then a clean walk
    repeat (6) flush_walk();
    walk(2, make_pte(44'h5678, 8'b11000111), 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);

    $display("mismatches %0d, memory errors %0d, timeouts %0d", mism, mem_errors, timeouts);
    if (mism == 0 && mem_errors == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/tb_ptw_mem.sv
`default_nettype none

module tb_ptw_mem (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  ptw_pkg::dc_req_t   req_i,
  output ptw_pkg::dc_rsp_t   rsp_o,
  output int unsigned        errors_o
);
  timeunit 1ns;
  timeprecision 1ns;

  // sparse page table keyed by physical byte address
  logic [ptw_pkg::XLEN-1:0] pt_mem [logic [ptw_pkg::PLEN-1:0]];
  logic [ptw_pkg::PLEN-1:0] exp_addr_q [$];
  integer seed = 60947;
  int unsigned gnt_wait;
  int unsigned rv_wait;
  logic busy;
  logic gnt;
  logic gnt_d1;
  logic rvalid_q;
  logic [ptw_pkg::XLEN-1:0] rdata_q;
  logic [ptw_pkg::PLEN-1:0] addr;
  logic [ptw_pkg::PLEN-1:0] addr_q;

  task automatic write_pte(input logic [ptw_pkg::PLEN-1:0] a, input ptw_pkg::pte_t pte);
    pt_mem[a] = pte;
  endtask

  task automatic expect_addr(input logic [ptw_pkg::PLEN-1:0] a);
    exp_addr_q.push_back(a);
  endtask

  task automatic clear_expected();
    exp_addr_q.delete();
  endtask

  assign addr = {req_i.address_tag, req_i.address_index};
  // grant only while a request is up and no response is pending
  assign gnt = req_i.data_req && !busy && (gnt_wait == 0);
  assign rsp_o.data_gnt    = gnt;
  assign rsp_o.data_rvalid = rvalid_q;
  assign rsp_o.data_rdata  = rdata_q;

  // ------------------------------
  // grant and response timing
  // ------------------------------
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy     <= 1'b0;
      gnt_d1   <= 1'b0;
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
      gnt_wait <= 0;
      rv_wait  <= 0;
      errors_o <= 0;
    end else begin
      gnt_d1   <= gnt;
      rvalid_q <= 1'b0;
      // tag must follow each grant by exactly one cycle
      assert (req_i.tag_valid == gnt_d1) else begin
        errors_o <= errors_o + 1;
        $display("Mismatch at %0t: tag_valid %b, expected %b", $time, req_i.tag_valid, gnt_d1);
      end
      if (gnt) begin
        busy    <= 1'b1;
        addr_q  <= addr;
        rv_wait <= $unsigned($random(seed)) % 4;
        if (exp_addr_q.size() == 0) begin
          errors_o <= errors_o + 1;
          $display("Error at %0t: request to %h that no walk step expects", $time, addr);
        end else begin
          assert (addr == exp_addr_q[0]) else begin
            errors_o <= errors_o + 1;
            $display("Mismatch at %0t: pte address %h, expected %h", $time, addr,
                     exp_addr_q[0]);
          end
          void'(exp_addr_q.pop_front());
        end
      end else if (busy) begin
        if (rv_wait == 0) begin
          busy     <= 1'b0;
          rvalid_q <= 1'b1;
          rdata_q  <= pt_mem.exists(addr_q) ? pt_mem[addr_q] : '0;
          gnt_wait <= $unsigned($random(seed)) % 4;
        end else begin
          rv_wait <= rv_wait - 1;
        end
      end else if (req_i.data_req && gnt_wait != 0) begin
        gnt_wait <= gnt_wait - 1;
      end
    end
  end

endmodule

`default_nettype wire
